/* hdl/lc3b_types.sv */
package lc3b_types;

	// data and address word
	typedef logic [15:0] lc3b_word;

	// register index
	typedef logic [2:0] lc3b_reg;

	// condition codes and branch masks
	typedef logic [2:0] lc3b_nzp;

	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [2:0] {alu_add, alu_and, alu_not, alu_pass} lc3b_aluop;

endpackage : lc3b_types

/* hdl/lc3b_ctrl.sv */
package lc3b_ctrl;
	import lc3b_types::*;

	typedef struct packed {
		logic sr1_sel;
		logic sr2_sel;
		logic sh6_sel;
		logic imm_sel;
	} id_ctrl;

	typedef struct packed {
		logic [1:0] alumux1_sel;
		logic [1:0] alumux2_sel;
		lc3b_aluop  alu_ctrl;
	} ex_ctrl;

	// branch marks the instructions resolved against the cc register
	typedef struct packed {
		logic indirect;
		logic read;
		logic write;
		logic mem_byte_sig;
		logic branch;
	} mem_ctrl;

	typedef struct packed {
		logic       load_regfile;
		logic [1:0] regfilemux_sel;
		logic       load_cc;
		logic       destmux_sel;
	} wb_ctrl;

	typedef struct packed {
		id_ctrl  id;
		ex_ctrl  ex;
		mem_ctrl mem;
		wb_ctrl  wb;
	} ctrl_word;

	// pc here is already pc+2
	typedef struct packed {
		lc3b_word pc;
		lc3b_word instruction;
	} if_id_reg;

	typedef struct packed {
		ex_ctrl   ex;
		mem_ctrl  mem;
		wb_ctrl   wb;
		lc3b_word pc;
		lc3b_word sr1;
		lc3b_word sr2;
		lc3b_word imm;
		lc3b_reg  dest;
		lc3b_nzp  nzp;
	} id_ex_reg;

	typedef struct packed {
		mem_ctrl  mem;
		wb_ctrl   wb;
		lc3b_word alu;
		lc3b_word store_data;
		lc3b_reg  dest;
		lc3b_nzp  nzp;
	} ex_mem_reg;

	typedef struct packed {
		wb_ctrl   wb;
		lc3b_word alu;
		lc3b_word mdr;
		lc3b_reg  dest;
	} mem_wb_reg;

endpackage : lc3b_ctrl

/* hdl/decode.sv */
module decode import lc3b_types::*, lc3b_ctrl::*; (
	input  lc3b_word instruction,
	output ctrl_word ctrl
);

	lc3b_opcode opcode;
	logic       ir5;

	assign opcode = lc3b_opcode'(instruction[15:12]);
	assign ir5 = instruction[5];

	always_comb begin
		// no-op word unless the opcode is one we run
		ctrl = '0;
		ctrl.ex.alu_ctrl = alu_pass;

		case (opcode)
			op_add: begin
				ctrl.id = '{sr1_sel: 1'b0, sr2_sel: 1'b0, sh6_sel: 1'b0, imm_sel: 1'b0};
				ctrl.ex.alumux1_sel = 2'b00;
				// register or imm5 form
				ctrl.ex.alumux2_sel = ir5 ? 2'b11 : 2'b00;
				ctrl.ex.alu_ctrl = alu_add;
				ctrl.mem = '{indirect: 1'b0, read: 1'b0, write: 1'b0,
					mem_byte_sig: 1'b0, branch: 1'b0};
				ctrl.wb = '{load_regfile: 1'b1, regfilemux_sel: 2'b10,
					load_cc: 1'b1, destmux_sel: 1'b0};
			end

			op_and: begin
				ctrl.id = '{sr1_sel: 1'b0, sr2_sel: 1'b0, sh6_sel: 1'b0, imm_sel: 1'b0};
				ctrl.ex.alumux1_sel = 2'b00;
				ctrl.ex.alumux2_sel = ir5 ? 2'b11 : 2'b00;
				ctrl.ex.alu_ctrl = alu_and;
				ctrl.mem = '{indirect: 1'b0, read: 1'b0, write: 1'b0,
					mem_byte_sig: 1'b0, branch: 1'b0};
				ctrl.wb = '{load_regfile: 1'b1, regfilemux_sel: 2'b10,
					load_cc: 1'b1, destmux_sel: 1'b0};
			end

			op_not: begin
				ctrl.id = '{sr1_sel: 1'b0, sr2_sel: 1'b0, sh6_sel: 1'b0, imm_sel: 1'b0};
				ctrl.ex.alumux1_sel = 2'b00;
				ctrl.ex.alumux2_sel = 2'b00;
				ctrl.ex.alu_ctrl = alu_not;
				ctrl.mem = '{indirect: 1'b0, read: 1'b0, write: 1'b0,
					mem_byte_sig: 1'b0, branch: 1'b0};
				ctrl.wb = '{load_regfile: 1'b1, regfilemux_sel: 2'b10,
					load_cc: 1'b1, destmux_sel: 1'b0};
			end

			op_ldr: begin
				ctrl.id = '{sr1_sel: 1'b0, sr2_sel: 1'b0, sh6_sel: 1'b1, imm_sel: 1'b0};
				// base + offset6*2
				ctrl.ex.alumux1_sel = 2'b00;
				ctrl.ex.alumux2_sel = 2'b01;
				ctrl.ex.alu_ctrl = alu_add;
				ctrl.mem = '{indirect: 1'b0, read: 1'b1, write: 1'b0,
					mem_byte_sig: 1'b0, branch: 1'b0};
				ctrl.wb = '{load_regfile: 1'b1, regfilemux_sel: 2'b00,
					load_cc: 1'b1, destmux_sel: 1'b0};
			end

			op_str: begin
				// sr2 reads the source register from bits 11:9
				ctrl.id = '{sr1_sel: 1'b0, sr2_sel: 1'b1, sh6_sel: 1'b1, imm_sel: 1'b0};
				ctrl.ex.alumux1_sel = 2'b00;
				ctrl.ex.alumux2_sel = 2'b01;
				ctrl.ex.alu_ctrl = alu_add;
				ctrl.mem = '{indirect: 1'b0, read: 1'b0, write: 1'b1,
					mem_byte_sig: 1'b0, branch: 1'b0};
				ctrl.wb = '{load_regfile: 1'b0, regfilemux_sel: 2'b00,
					load_cc: 1'b0, destmux_sel: 1'b0};
			end

			op_br: begin
				ctrl.id = '{sr1_sel: 1'b0, sr2_sel: 1'b0, sh6_sel: 1'b0, imm_sel: 1'b0};
				// target is pc+2 + offset9*2
				ctrl.ex.alumux1_sel = 2'b01;
				ctrl.ex.alumux2_sel = 2'b10;
				ctrl.ex.alu_ctrl = alu_add;
				ctrl.mem = '{indirect: 1'b0, read: 1'b0, write: 1'b0,
					mem_byte_sig: 1'b0, branch: 1'b1};
				ctrl.wb = '{load_regfile: 1'b0, regfilemux_sel: 2'b00,
					load_cc: 1'b0, destmux_sel: 1'b0};
			end

			default: begin
				ctrl = '0;
				ctrl.ex.alu_ctrl = alu_pass;
			end
		endcase
	end

endmodule : decode

/* hdl/regfile.sv */
module regfile import lc3b_types::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     we,
	input  lc3b_reg  dest,
	input  lc3b_word wdata,
	input  lc3b_reg  src_a,
	input  lc3b_reg  src_b,
	output lc3b_word data_a,
	output lc3b_word data_b
);

	lc3b_word regs [8];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[dest] <= wdata;
		end
	end

	// write-first so decode sees the value written back this cycle
	assign data_a = (we && dest == src_a) ? wdata : regs[src_a];
	assign data_b = (we && dest == src_b) ? wdata : regs[src_b];

endmodule : regfile

/* hdl/fetch_stage.sv */
module fetch_stage import lc3b_types::*, lc3b_ctrl::*; #(
	parameter lc3b_word RESET_PC = 16'h0000
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     branch_taken,
	input  lc3b_word branch_target,
	output lc3b_word imem_addr,
	input  lc3b_word imem_rdata,
	output if_id_reg if_id
);

	lc3b_word pc;
	lc3b_word pc_plus2;

	assign pc_plus2 = pc + 16'd2;
	assign imem_addr = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else begin
			pc <= branch_taken ? branch_target : pc_plus2;
		end
	end

	always_ff @(posedge clk) begin
		if_id.pc <= pc_plus2;
		// all-zero word decodes as BR with empty mask
		if (rst) begin
			if_id.instruction <= '0;
		end else begin
			if_id.instruction <= imem_rdata;
		end
	end

endmodule : fetch_stage

/* hdl/id_stage.sv */
module id_stage import lc3b_types::*, lc3b_ctrl::*; (
	input  logic     clk,
	input  logic     rst,
	input  if_id_reg if_id,
	output lc3b_reg  src_a,
	output lc3b_reg  src_b,
	input  lc3b_word data_a,
	input  lc3b_word data_b,
	output id_ex_reg id_ex
);

	ctrl_word ctrl;
	lc3b_word ir;
	lc3b_word imm;
	lc3b_reg  dest;

	assign ir = if_id.instruction;

	decode decode_inst (
		.instruction(ir),
		.ctrl(ctrl)
	);

	assign src_a = ctrl.id.sr1_sel ? ir[11:9] : ir[8:6];
	assign src_b = ctrl.id.sr2_sel ? ir[11:9] : ir[2:0];

	// r7 is the link register
	assign dest = ctrl.wb.destmux_sel ? 3'b111 : ir[11:9];

	always_comb begin
		if (ctrl.id.sh6_sel) begin
			imm = {{9{ir[5]}}, ir[5:0], 1'b0};
		end else if (ctrl.ex.alumux2_sel == 2'b10) begin
			imm = {{6{ir[8]}}, ir[8:0], 1'b0};
		end else begin
			imm = {{11{ir[4]}}, ir[4:0]};
		end
	end

	always_ff @(posedge clk) begin
		id_ex.pc <= if_id.pc;
		id_ex.sr1 <= data_a;
		id_ex.sr2 <= data_b;
		id_ex.imm <= imm;
		id_ex.dest <= dest;
		id_ex.nzp <= ir[11:9];
		if (rst) begin
			id_ex.ex <= '0;
			id_ex.mem <= '0;
			id_ex.wb <= '0;
		end else begin
			id_ex.ex <= ctrl.ex;
			id_ex.mem <= ctrl.mem;
			id_ex.wb <= ctrl.wb;
		end
	end

	// a load and a store never share a slot downstream
	assert property (@(posedge clk) disable iff (rst) !(id_ex.mem.read && id_ex.mem.write))
		else $error("id_ex holds both read and write");

endmodule : id_stage

/* hdl/ex_stage.sv */
module ex_stage import lc3b_types::*, lc3b_ctrl::*; (
	input  logic      clk,
	input  logic      rst,
	input  id_ex_reg  id_ex,
	output ex_mem_reg ex_mem
);

	lc3b_word alu_a;
	lc3b_word alu_b;
	lc3b_word alu_out;

	always_comb begin
		case (id_ex.ex.alumux1_sel)
			2'b01:   alu_a = id_ex.pc;
			default: alu_a = id_ex.sr1;
		endcase
	end

	// 01 offset6, 10 offset9 and 11 imm5 are all prepared in decode
	always_comb begin
		case (id_ex.ex.alumux2_sel)
			2'b00:   alu_b = id_ex.sr2;
			default: alu_b = id_ex.imm;
		endcase
	end

	always_comb begin
		case (id_ex.ex.alu_ctrl)
			alu_add: alu_out = alu_a + alu_b;
			alu_and: alu_out = alu_a & alu_b;
			alu_not: alu_out = ~alu_a;
			default: alu_out = alu_a;
		endcase
	end

	always_ff @(posedge clk) begin
		ex_mem.alu <= alu_out;
		// str source register rides along on sr2
		ex_mem.store_data <= id_ex.sr2;
		ex_mem.dest <= id_ex.dest;
		ex_mem.nzp <= id_ex.nzp;
		if (rst) begin
			ex_mem.mem <= '0;
			ex_mem.wb <= '0;
		end else begin
			ex_mem.mem <= id_ex.mem;
			ex_mem.wb <= id_ex.wb;
		end
	end

endmodule : ex_stage

/* hdl/mem_wb_stage.sv */
module mem_wb_stage import lc3b_types::*, lc3b_ctrl::*; (
	input  logic      clk,
	input  logic      rst,
	input  ex_mem_reg ex_mem,
	output lc3b_word  dmem_addr,
	output lc3b_word  dmem_wdata,
	output logic      dmem_read,
	output logic      dmem_write,
	input  lc3b_word  dmem_rdata,
	output logic      branch_taken,
	output lc3b_word  branch_target,
	output logic      reg_we,
	output lc3b_reg   reg_dest,
	output lc3b_word  reg_wdata
);

	mem_wb_reg mem_wb;
	lc3b_nzp   cc;
	lc3b_nzp   cc_next;

	assign dmem_addr = ex_mem.alu;
	assign dmem_wdata = ex_mem.store_data;
	assign dmem_read = ex_mem.mem.read;
	assign dmem_write = ex_mem.mem.write;

	// taken when mask and flags overlap
	assign branch_taken = ex_mem.mem.branch && |(ex_mem.nzp & cc);
	assign branch_target = ex_mem.alu;

	always_ff @(posedge clk) begin
		mem_wb.alu <= ex_mem.alu;
		mem_wb.mdr <= dmem_rdata;
		mem_wb.dest <= ex_mem.dest;
		if (rst) begin
			mem_wb.wb <= '0;
		end else begin
			mem_wb.wb <= ex_mem.wb;
		end
	end

	assign reg_wdata = (mem_wb.wb.regfilemux_sel == 2'b00) ? mem_wb.mdr : mem_wb.alu;
	assign reg_we = mem_wb.wb.load_regfile;
	assign reg_dest = mem_wb.dest;

	always_comb begin
		if (reg_wdata[15]) begin
			cc_next = 3'b100;
		end else if (reg_wdata == '0) begin
			cc_next = 3'b010;
		end else begin
			cc_next = 3'b001;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cc <= '0;
		end else if (mem_wb.wb.load_cc) begin
			cc <= cc_next;
		end
	end

	// a taken branch neither touches memory nor writes a register
	assert property (@(posedge clk) disable iff (rst)
		branch_taken |-> !(ex_mem.mem.read || ex_mem.mem.write || ex_mem.wb.load_regfile))
		else $error("taken branch carries a memory access or register write");

	// decoder never emits the indirect or byte modes
	assert property (@(posedge clk) disable iff (rst)
		!(ex_mem.mem.indirect || ex_mem.mem.mem_byte_sig))
		else $error("unsupported memory mode reached mem");

endmodule : mem_wb_stage

/* hdl/lc3b_cpu.sv */
module lc3b_cpu import lc3b_types::*, lc3b_ctrl::*; #(
	parameter lc3b_word RESET_PC = 16'h0000
) (
	input  logic     clk,
	input  logic     rst,
	output lc3b_word imem_addr,
	input  lc3b_word imem_rdata,
	output lc3b_word dmem_addr,
	output lc3b_word dmem_wdata,
	output logic     dmem_read,
	output logic     dmem_write,
	input  lc3b_word dmem_rdata
);

	if_id_reg  if_id;
	id_ex_reg  id_ex;
	ex_mem_reg ex_mem;
	logic      branch_taken;
	lc3b_word  branch_target;
	logic      reg_we;
	lc3b_reg   reg_dest;
	lc3b_word  reg_wdata;
	lc3b_reg   src_a;
	lc3b_reg   src_b;
	lc3b_word  data_a;
	lc3b_word  data_b;

	fetch_stage #(.RESET_PC(RESET_PC)) fetch_stage_inst (
		.clk(clk),
		.rst(rst),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.if_id(if_id)
	);

	id_stage id_stage_inst (
		.clk(clk),
		.rst(rst),
		.if_id(if_id),
		.src_a(src_a),
		.src_b(src_b),
		.data_a(data_a),
		.data_b(data_b),
		.id_ex(id_ex)
	);

	ex_stage ex_stage_inst (
		.clk(clk),
		.rst(rst),
		.id_ex(id_ex),
		.ex_mem(ex_mem)
	);

	mem_wb_stage mem_wb_stage_inst (
		.clk(clk),
		.rst(rst),
		.ex_mem(ex_mem),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_read(dmem_read),
		.dmem_write(dmem_write),
		.dmem_rdata(dmem_rdata),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.reg_we(reg_we),
		.reg_dest(reg_dest),
		.reg_wdata(reg_wdata)
	);

	regfile regfile_inst (
		.clk(clk),
		.rst(rst),
		.we(reg_we),
		.dest(reg_dest),
		.wdata(reg_wdata),
		.src_a(src_a),
		.src_b(src_b),
		.data_a(data_a),
		.data_b(data_b)
	);

endmodule : lc3b_cpu

/* testbench/lc3b_cpu_tb.sv */
module lc3b_cpu_tb import lc3b_types::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam lc3b_word RESET_PC = 16'h0100;
	localparam int MARKER_OFF = 30;
	localparam lc3b_word MARKER_ADDR = 16'(MARKER_OFF * 2);
	localparam int MAX_STORES = 64;

	logic     clk;
	logic     rst;
	lc3b_word imem_addr;
	lc3b_word imem_rdata;
	lc3b_word dmem_addr;
	lc3b_word dmem_wdata;
	logic     dmem_read;
	logic     dmem_write;
	lc3b_word dmem_rdata;

	lc3b_word imem [512];
	lc3b_word dmem [256];
	lc3b_word dmem_init [256];
	int       instr_test [512];
	int       prog_len;
	int       cur_test;
	logic [31:0] lfsr;

	// expected store stream from the reference model
	lc3b_word exp_addr [MAX_STORES];
	lc3b_word exp_data [MAX_STORES];
	int       exp_test [MAX_STORES];
	int       n_exp;
	int       test_last [6];
	logic     test_fail [6];
	string    test_name [6];
	int       store_idx;
	int       seen_idx;
	logic     seen_valid;
	int       passes;
	int       fails;
	int       other_errs;
	int       cycles;
	int       limit;

	lc3b_word next_addr;
	lc3b_word next_data;
	int       next_test;

	lc3b_cpu #(.RESET_PC(RESET_PC)) lc3b_cpu_inst (
		.clk(clk),
		.rst(rst),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_read(dmem_read),
		.dmem_write(dmem_write),
		.dmem_rdata(dmem_rdata)
	);

	always #20 clk = ~clk;

	// both memories answer in the same cycle
	assign imem_rdata = imem[imem_addr[9:1]];
	assign dmem_rdata = dmem[dmem_addr[8:1]];

	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 256; i++) begin
				dmem[i] <= dmem_init[i];
			end
		end else if (dmem_write) begin
			dmem[dmem_addr[8:1]] <= dmem_wdata;
		end
	end

	function automatic lc3b_word enc_rr(logic [3:0] op, lc3b_reg dr, lc3b_reg sa, lc3b_reg sb);
		return {op, dr, sa, 3'b000, sb};
	endfunction

	function automatic lc3b_word enc_ri(logic [3:0] op, lc3b_reg dr, lc3b_reg sa, int imm);
		return {op, dr, sa, 1'b1, imm[4:0]};
	endfunction

	function automatic lc3b_word enc_mem(logic [3:0] op, lc3b_reg r, lc3b_reg base, int off);
		return {op, r, base, off[5:0]};
	endfunction

	function automatic lc3b_word enc_br(lc3b_nzp mask, int off);
		return {4'b0000, mask, off[8:0]};
	endfunction

	function automatic lc3b_nzp flags_of(lc3b_word v);
		if (v[15]) begin
			return 3'b100;
		end
		return (v == 16'h0) ? 3'b010 : 3'b001;
	endfunction

	// galois lfsr for x^32 + x^22 + x^2 + x + 1
	task automatic random_bits(input int n, output lc3b_word v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
	endtask

	task automatic emit(input lc3b_word w);
		imem[RESET_PC[9:1] + prog_len] = w;
		instr_test[prog_len] = cur_test;
		prog_len++;
	endtask

	// three no-ops keep dependent instructions apart
	task automatic emit_spaced(input lc3b_word w);
		emit(w);
		repeat (3) emit(16'h0000);
	endtask

	// taken branch over a marker store with no-op delay slots
	task automatic emit_skip(input lc3b_nzp mask, input lc3b_reg r, input int off);
		int b;
		b = prog_len;
		emit_spaced(16'h0000);
		emit_spaced(enc_mem(4'b0111, r, 3'd0, MARKER_OFF));
		imem[RESET_PC[9:1] + b] = enc_br(mask, prog_len - (b + 1));
		emit_spaced(enc_mem(4'b0111, r, 3'd0, off));
	endtask

	task automatic build_program();
		lc3b_word w;
		for (int i = 0; i < 512; i++) begin
			imem[i] = 16'h0000;
		end
		for (int i = 0; i < 256; i++) begin
			dmem_init[i] = (16'(i) * 16'h0101) ^ 16'ha5c3;
		end
		for (int i = 0; i < 8; i++) begin
			random_bits(16, w);
			dmem_init[i] = w;
		end
		prog_len = 0;
		cur_test = 1;
		for (int k = 0; k < 4; k++) begin
			emit_spaced(enc_mem(4'b0110, 3'd1, 3'd0, k));
			emit_spaced(enc_mem(4'b0111, 3'd1, 3'd0, 16 + k));
		end
		cur_test = 2;
		emit_spaced(enc_mem(4'b0110, 3'd1, 3'd0, 4));
		emit_spaced(enc_mem(4'b0110, 3'd2, 3'd0, 5));
		emit_spaced(enc_rr(4'b0001, 3'd3, 3'd1, 3'd2));
		emit_spaced(enc_mem(4'b0111, 3'd3, 3'd0, 20));
		emit_spaced(enc_ri(4'b0001, 3'd4, 3'd1, -7));
		emit_spaced(enc_mem(4'b0111, 3'd4, 3'd0, 21));
		emit_spaced(enc_ri(4'b0001, 3'd4, 3'd0, -16));
		emit_spaced(enc_mem(4'b0111, 3'd4, 3'd0, 22));
		emit_spaced(enc_ri(4'b0001, 3'd4, 3'd2, 15));
		emit_spaced(enc_mem(4'b0111, 3'd4, 3'd0, 23));
		cur_test = 3;
		emit_spaced(enc_rr(4'b0101, 3'd3, 3'd1, 3'd2));
		emit_spaced(enc_mem(4'b0111, 3'd3, 3'd0, 10));
		emit_spaced(enc_ri(4'b0101, 3'd4, 3'd1, -3));
		emit_spaced(enc_mem(4'b0111, 3'd4, 3'd0, 11));
		emit_spaced(enc_ri(4'b0101, 3'd4, 3'd2, 9));
		emit_spaced(enc_mem(4'b0111, 3'd4, 3'd0, 12));
		emit_spaced({4'b1001, 3'd5, 3'd2, 6'b111111});
		emit_spaced(enc_mem(4'b0111, 3'd5, 3'd0, 13));
		cur_test = 4;
		emit_spaced(enc_ri(4'b0001, 3'd6, 3'd0, -5));
		emit_skip(3'b100, 3'd6, 24);
		emit_spaced(enc_ri(4'b0001, 3'd6, 3'd0, 0));
		emit_skip(3'b010, 3'd6, 25);
		cur_test = 5;
		emit_spaced(enc_ri(4'b0001, 3'd6, 3'd0, 3));
		emit_spaced(enc_br(3'b110, 4));
		emit_spaced(enc_mem(4'b0111, 3'd6, 3'd0, 26));
		emit_spaced(enc_br(3'b000, 4));
		emit_spaced(enc_mem(4'b0111, 3'd6, 3'd0, 27));
		repeat (4) emit(16'h0000);
	endtask

	// sequential ISA model where the no-op delay slots drop out
	task automatic compute_expected();
		lc3b_word r [8];
		lc3b_word m [256];
		lc3b_nzp  cc;
		lc3b_word pc;
		lc3b_word ir;
		lc3b_word b;
		lc3b_word res;
		lc3b_word addr;
		int       k;
		r = '{default: '0};
		m = dmem_init;
		cc = '0;
		pc = RESET_PC;
		n_exp = 0;
		while (pc < RESET_PC + 16'(2 * prog_len)) begin
			ir = imem[pc[9:1]];
			k = int'(pc - RESET_PC) / 2;
			pc = pc + 16'd2;
			addr = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
			b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
			case (ir[15:12])
				4'b0001, 4'b0101, 4'b1001, 4'b0110: begin
					if (ir[15:12] == 4'b0001) begin
						res = r[ir[8:6]] + b;
					end else if (ir[15:12] == 4'b0101) begin
						res = r[ir[8:6]] & b;
					end else if (ir[15:12] == 4'b1001) begin
						res = ~r[ir[8:6]];
					end else begin
						res = m[addr[8:1]];
					end
					r[ir[11:9]] = res;
					cc = flags_of(res);
				end
				4'b0111: begin
					exp_addr[n_exp] = addr;
					exp_data[n_exp] = r[ir[11:9]];
					exp_test[n_exp] = instr_test[k];
					test_last[instr_test[k]] = n_exp;
					m[addr[8:1]] = r[ir[11:9]];
					n_exp++;
				end
				4'b0000: begin
					if (|(ir[11:9] & cc)) begin
						pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
					end
				end
				default: begin
				end
			endcase
		end
		test_last[0] = 0;
	endtask

	assign next_addr = (store_idx < n_exp) ? exp_addr[store_idx] : '0;
	assign next_data = (store_idx < n_exp) ? exp_data[store_idx] : '0;
	assign next_test = (store_idx < n_exp) ? exp_test[store_idx] : 0;

	always @(posedge clk) begin
		if (!rst && dmem_write) begin
			store_idx <= store_idx + 1;
			seen_idx <= store_idx;
			seen_valid <= 1'b1;
		end else begin
			seen_valid <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		(dmem_write && store_idx < n_exp) |-> dmem_addr == next_addr)
		else begin
			$display("Mismatch at %0d ns: dmem_addr got %h expected %h",
				$time, $sampled(dmem_addr), $sampled(next_addr));
			test_fail[$sampled(next_test)] = 1'b1;
		end

	assert property (@(posedge clk) disable iff (rst)
		(dmem_write && store_idx < n_exp) |-> dmem_wdata == next_data)
		else begin
			$display("Mismatch at %0d ns: dmem_wdata got %h expected %h",
				$time, $sampled(dmem_wdata), $sampled(next_data));
			test_fail[$sampled(next_test)] = 1'b1;
		end

	assert property (@(posedge clk) disable iff (rst) dmem_write |-> store_idx < n_exp)
		else begin
			$display("a data write happened after the last expected store at %0d ns", $time);
			other_errs++;
		end

	assert property (@(posedge clk) disable iff (rst) dmem_write |-> dmem_addr != MARKER_ADDR)
		else begin
			$display("the marker store behind a taken branch was executed at %0d ns", $time);
			test_fail[4] = 1'b1;
		end

	assert property (@(posedge clk) rst |=> imem_addr == RESET_PC)
		else begin
			$display("Mismatch at %0d ns: imem_addr got %h expected %h",
				$time, $sampled(imem_addr), RESET_PC);
			test_fail[0] = 1'b1;
		end

	assert property (@(posedge clk) rst |=> !dmem_write && !dmem_read)
		else begin
			$display("a data strobe was active right after reset at %0d ns", $time);
			test_fail[0] = 1'b1;
		end

	// report on the falling edge after the rising edge's checks
	always @(negedge clk) begin
		if (seen_valid) begin
			for (int t = 0; t < 6; t++) begin
				if (test_last[t] == seen_idx) begin
					$display("test %0d %s: %s", t, test_name[t], test_fail[t] ? "fail" : "pass");
					if (test_fail[t]) begin
						fails++;
					end else begin
						passes++;
					end
				end
			end
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		lfsr = 32'h4bcb;
		store_idx = 0;
		seen_idx = 0;
		seen_valid = 1'b0;
		passes = 0;
		fails = 0;
		other_errs = 0;
		cycles = 0;
		test_name = '{"reset", "ldr/str copy", "add", "and/not", "br taken", "br not taken"};
		for (int t = 0; t < 6; t++) begin
			test_fail[t] = 1'b0;
			test_last[t] = -1;
		end
		build_program();
		compute_expected();
		limit = 4 * prog_len + 50;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		while (store_idx < n_exp && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (cycles >= limit) begin
			$display("timeout after %0d cycles with %0d of %0d stores seen",
				cycles, store_idx, n_exp);
			$display("Test FAILED");
		end else begin
			repeat (12) @(posedge clk);
			$display("tests passed %0d, failed %0d, other errors %0d", passes, fails, other_errs);
			if (fails == 0 && other_errs == 0 && passes == 6) begin
				$display("Test OK");
			end else begin
				$display("Test FAILED");
			end
		end
		$finish;
	end

endmodule : lc3b_cpu_tb

/* project.f */
hdl/lc3b_types.sv
hdl/lc3b_ctrl.sv
hdl/decode.sv
hdl/regfile.sv
hdl/fetch_stage.sv
hdl/id_stage.sv
hdl/ex_stage.sv
hdl/mem_wb_stage.sv
hdl/lc3b_cpu.sv
testbench/lc3b_cpu_tb.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = lc3b_cpu_tb
FILELIST   = project.f

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
